/* files.f */
+incdir+include
src/bgpu_pkg.sv
src/warp_arbiter.sv
src/fetcher.sv
src/inst_mem.sv
src/decoder.sv
src/front_end.sv
sim/front_end_props.sv
sim/tb_front_end.sv

/* include/bgpu_defs.svh */
// Size and encoding macros for the SIMT front end
// Widths of warp state, program counter, register indices and instruction words
`ifndef BGPU_DEFS_SVH
`define BGPU_DEFS_SVH

// Warps held by one core
`define BGPU_NUM_WARPS 8

// Program counter counts words, so the memory depth follows from it
`define BGPU_PC_WIDTH 8
`define BGPU_IMEM_DEPTH 256

// Threads per warp, one bit each in the active mask
`define BGPU_WARP_WIDTH 32

// Register index width for destination and operands
`define BGPU_REG_IDX_WIDTH 8

// Encoded instruction word
`define BGPU_INST_WIDTH 32

// Top byte of a word that retires the warp
`define BGPU_STOP_OPCODE 8'hFF

`endif

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_front_end \
    -o tb_front_end > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_front_end > sim.log 2>&1 || { echo "Run aborted, see sim.log"; exit 1; }
grep -q "Simulation FAILED" sim.log && { echo "Test failed, see sim.log"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "No result in sim.log"; exit 1; }
echo "Test passed"

/* sim/front_end_props.sv */
// Assertions for the SIMT front end
// Dispatcher handshake stability, reset state and done strobes of running warps
`include "bgpu_defs.svh"

module front_end_props (
    input logic               clk_i,
    input logic               rst_n_i,
    input logic               launch_i,
    input bgpu_pkg::wid_t     launch_wid_i,
    input logic               disp_ready_i,
    input logic               dec_valid_i,
    input bgpu_pkg::dec_out_t dec_i,
    input logic               warp_done_i,
    input bgpu_pkg::wid_t     done_wid_i
);
    import bgpu_pkg::*;

    // Shadow of the warps that are running
    logic [`BGPU_NUM_WARPS-1:0] busy_q;

    // Number of failed properties so far
    int fail_count;

    always_ff @(posedge clk_i) begin : busy_track
        if (!rst_n_i) begin
            busy_q <= '0;
        end else begin
            if (warp_done_i) begin
                busy_q[done_wid_i] <= 1'b0;
            end
            if (launch_i && !busy_q[launch_wid_i]) begin
                busy_q[launch_wid_i] <= 1'b1;
            end
        end
    end

    hold_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dec_valid_i && !disp_ready_i |=> dec_valid_i && $stable(dec_i))
        else begin
            $error("dec_o changed while the dispatcher stalled");
            fail_count++;
        end

    done_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        warp_done_i |-> busy_q[done_wid_i])
        else begin
            $error("warp_done_o for a warp that is not running");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |=> !dec_valid_i && !warp_done_i)
        else begin
            $error("Outputs active right after reset");
            fail_count++;
        end

endmodule : front_end_props

bind front_end front_end_props i_front_end_props (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .launch_i     (launch_i),
    .launch_wid_i (launch_wid_i),
    .disp_ready_i (disp_ready_i),
    .dec_valid_i  (dec_valid_o),
    .dec_i        (dec_o),
    .warp_done_i  (warp_done_o),
    .done_wid_i   (done_wid_o)
);

/* sim/front_end_vectors.txt */
# L addr word | S warp pc mask | E warp opcode dst required op0 op1, all hex
# The second launch of warp 0 hits a busy warp and must be ignored
S 0 10 ffffffff
S 0 20 0000000f
S 3 20 0000ffff
S 5 30 00ff00ff
S 2 40 80000001
L 10 00010203
L 11 06040507
L 12 1008090a
L 13 ff000000
L 20 010b0c0d
L 21 080e0f10
L 22 35111213
L 23 ff000000
L 30 0c141516
L 31 07171819
L 32 ff000000
L 40 ff000000
E 0 00 01 3 02 03
E 0 06 04 2 05 07
E 0 10 08 3 09 0a
E 3 01 0b 3 0c 0d
E 3 08 0e 2 0f 10
E 3 35 11 0 12 13
E 5 0c 14 0 15 16
E 5 07 17 2 18 19

/* sim/tb_front_end.sv */
// Testbench for the SIMT front end
// Loads program and launches from a vector file, plays a random dispatcher
// and checks decoded words and done strobes against per-warp queues
`include "bgpu_defs.svh"

module tb_front_end;
    import bgpu_pkg::*;

    localparam int unsigned NumWarps = `BGPU_NUM_WARPS;

    typedef struct packed {
        pc_t       addr;
        enc_inst_t word;
    } load_t;

    logic      clk_i;
    logic      rst_n_i;
    logic      imem_we_i;
    pc_t       imem_addr_i;
    enc_inst_t imem_wdata_i;
    logic      launch_i;
    wid_t      launch_wid_i;
    pc_t       launch_pc_i;
    act_mask_t launch_mask_i;
    logic      disp_ready_i;
    logic      dec_valid_o;
    dec_out_t  dec_o;
    logic      warp_done_o;
    wid_t      done_wid_o;

    load_t      load_q [$];
    fetch_req_t launch_q [$];
    dec_out_t   exp_q [NumWarps][$];
    logic       launched [NumWarps];
    logic       finished [NumWarps];
    pc_t        start_pc [NumWarps];
    act_mask_t  start_mask [NumWarps];
    int         errors;
    int         checks;
    int         n_exp;
    int         cycles;

    front_end DUT (.*);

    initial begin : clock
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin : cycle_count
        cycles++;
    end

    // Dispatcher accepts about three cycles in four
    initial begin : dispatcher
        void'($urandom(32'h95272515));
        forever begin
            @(posedge clk_i);
            #10;
            disp_ready_i = ($urandom % 4) != 0;
        end
    end

    task automatic compare_dec(input dec_out_t got, input dec_out_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t dec_o got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic compare_done(input wid_t got, input logic [NumWarps-1:0] allowed);
        checks++;
        if (!allowed[got]) begin
            errors++;
            $display("[ERROR] %0t done_wid_o got %0d expected one of %b", $time, got, allowed);
        end
    endtask

    // Running warps with nothing left to transfer may retire
    function automatic logic [NumWarps-1:0] retire_mask();
        logic [NumWarps-1:0] mask;
        for (int w = 0; w < NumWarps; w++) begin
            mask[w] = launched[w] && !finished[w] && exp_q[w].size() == 0;
        end
        return mask;
    endfunction

    function automatic logic all_finished();
        for (int w = 0; w < NumWarps; w++) begin
            if ((launched[w] && !finished[w]) || exp_q[w].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Handshake values are settled by the falling edge
    always @(negedge clk_i) begin : monitor
        if (rst_n_i && dec_valid_o && disp_ready_i) begin
            if (exp_q[dec_o.wid].size() == 0) begin
                errors++;
                $display("Unexpected transfer from warp %0d at pc %h", dec_o.wid, dec_o.pc);
            end else begin
                compare_dec(dec_o, exp_q[dec_o.wid].pop_front());
            end
        end
        if (rst_n_i && warp_done_o) begin
            compare_done(done_wid_o, retire_mask());
            finished[done_wid_o] = 1'b1;
        end
    end

    task automatic read_vectors();
        int          fd;
        string       line;
        logic [31:0] a, b, c, d, e, g;
        wid_t        w;
        load_t       ld;
        fetch_req_t  lr;
        dec_out_t    exp;
        fd = $fopen("sim/front_end_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open the vector file");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h", a, b, c, d, e, g));
            case (line[0])
                "L": begin
                    ld.addr = pc_t'(a);
                    ld.word = b;
                    load_q.push_back(ld);
                end
                "S": begin
                    lr.wid      = wid_t'(a);
                    lr.pc       = pc_t'(b);
                    lr.act_mask = c;
                    launch_q.push_back(lr);
                    // A repeated launch hits a busy warp and has no effect
                    if (!launched[lr.wid]) begin
                        launched[lr.wid]   = 1'b1;
                        start_pc[lr.wid]   = lr.pc;
                        start_mask[lr.wid] = lr.act_mask;
                    end
                end
                "E": begin
                    w = wid_t'(a);
                    exp.pc                = start_pc[w] + pc_t'(exp_q[w].size());
                    exp.act_mask          = start_mask[w];
                    exp.wid               = w;
                    exp.inst              = inst_t'(b[7:0]);
                    exp.dst               = c[7:0];
                    exp.operands_required = d[1:0];
                    exp.operands[0]       = e[7:0];
                    exp.operands[1]       = g[7:0];
                    exp_q[w].push_back(exp);
                    n_exp++;
                end
                default: begin
                    errors++;
                    $display("Unknown line in the vector file: %s", line);
                end
            endcase
        end
        $fclose(fd);
    endtask

    initial begin : main
        load_t      ld;
        fetch_req_t lr;
        int         limit;
        int         assert_fails;
        rst_n_i       = 1'b0;
        imem_we_i     = 1'b0;
        imem_addr_i   = '0;
        imem_wdata_i  = '0;
        launch_i      = 1'b0;
        launch_wid_i  = '0;
        launch_pc_i   = '0;
        launch_mask_i = '0;
        disp_ready_i  = 1'b0;
        errors        = 0;
        checks        = 0;
        n_exp         = 0;
        cycles        = 0;
        for (int w = 0; w < NumWarps; w++) begin
            launched[w] = 1'b0;
            finished[w] = 1'b0;
        end
        read_vectors();
        limit = 20 * n_exp + 200;

        repeat (2) @(posedge clk_i);
        #10;
        rst_n_i = 1'b1;
        while (load_q.size() > 0) begin
            ld = load_q.pop_front();
            imem_we_i    = 1'b1;
            imem_addr_i  = ld.addr;
            imem_wdata_i = ld.word;
            @(posedge clk_i);
            #10;
        end
        imem_we_i = 1'b0;
        while (launch_q.size() > 0) begin
            lr = launch_q.pop_front();
            launch_i      = 1'b1;
            launch_wid_i  = lr.wid;
            launch_pc_i   = lr.pc;
            launch_mask_i = lr.act_mask;
            @(posedge clk_i);
            #10;
        end
        launch_i = 1'b0;

        while (!all_finished() && cycles < limit) begin
            @(posedge clk_i);
        end
        if (!all_finished()) begin
            errors++;
            $display("Timeout after %0d cycles, some warps never retired", cycles);
        end
        assert_fails = DUT.i_front_end_props.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : tb_front_end

/* src/bgpu_pkg.sv */
// Shared types of the SIMT front end
// Opcode encodings, warp state and the structs passed between pipeline stages
`include "bgpu_defs.svh"

package bgpu_pkg;

    typedef logic [$clog2(`BGPU_NUM_WARPS)-1:0] wid_t;
    typedef logic [`BGPU_PC_WIDTH-1:0]           pc_t;
    typedef logic [`BGPU_WARP_WIDTH-1:0]         act_mask_t;
    typedef logic [`BGPU_REG_IDX_WIDTH-1:0]      reg_idx_t;
    typedef logic [`BGPU_INST_WIDTH-1:0]         enc_inst_t;

    // Execution unit, codes 2 to 15 have no unit behind them
    typedef enum logic [3:0] {
        EU_IU  = 4'h0,
        EU_LSU = 4'h1
    } eu_e;

    // Integer unit operations, register and immediate forms
    typedef enum logic [3:0] {
        IU_ADD  = 4'h0,
        IU_SUB  = 4'h1,
        IU_AND  = 4'h2,
        IU_OR   = 4'h3,
        IU_XOR  = 4'h4,
        IU_SLL  = 4'h5,
        IU_ADDI = 4'h6,
        IU_SUBI = 4'h7,
        IU_SLLI = 4'h8
    } iu_subtype_e;

    // Opcode byte, top of the instruction word
    typedef struct packed {
        eu_e         eu;
        iu_subtype_e subtype;
    } inst_t;

    // Per-warp state in the fetcher
    typedef enum logic [1:0] {
        WS_IDLE,
        WS_READY,
        WS_WAITING
    } warp_state_e;

    typedef struct packed {
        wid_t      wid;
        pc_t       pc;
        act_mask_t act_mask;
    } fetch_req_t;

    // Fetch metadata plus the word read from memory
    typedef struct packed {
        fetch_req_t req;
        enc_inst_t  word;
    } ic_out_t;

    typedef struct packed {
        pc_t                pc;
        act_mask_t          act_mask;
        wid_t               wid;
        inst_t              inst;
        reg_idx_t           dst;
        logic [1:0]         operands_required;
        reg_idx_t [1:0]     operands;
    } dec_out_t;

endpackage : bgpu_pkg

/* src/decoder.sv */
// Instruction decoder
// Splits words into dispatch fields, drives the dispatcher handshake
// and reports next PC and stop events back to the fetcher
`include "bgpu_defs.svh"

module decoder (
    // From the instruction memory stage
    input  logic                ic_valid_i,
    input  bgpu_pkg::ic_out_t   ic_i,
    output logic                dec_ready_o,

    // To the dispatcher
    input  logic                disp_ready_i,
    output logic                dec_valid_o,
    output bgpu_pkg::dec_out_t  dec_o,

    // To the fetcher
    output logic                dec_decoded_o,
    output logic                dec_stop_warp_o,
    output bgpu_pkg::wid_t      dec_decoded_warp_id_o,
    output bgpu_pkg::pc_t       dec_decoded_next_pc_o
);
    import bgpu_pkg::*;

    inst_t opcode;

    assign opcode = inst_t'(ic_i.word[31:24]);

    // No buffering here, the dispatcher sets the pace
    assign dec_ready_o = disp_ready_i;

    assign dec_stop_warp_o = ic_i.word[31:24] == `BGPU_STOP_OPCODE;
    assign dec_valid_o     = ic_valid_i && !dec_stop_warp_o;

    // Both a dispatched word and a stop word leave the stage on ready
    assign dec_decoded_o         = ic_valid_i && disp_ready_i;
    assign dec_decoded_warp_id_o = ic_i.req.wid;
    assign dec_decoded_next_pc_o = ic_i.req.pc + pc_t'(1);

    always_comb begin : decode
        dec_o.pc          = ic_i.req.pc;
        dec_o.act_mask    = ic_i.req.act_mask;
        dec_o.wid         = ic_i.req.wid;
        dec_o.inst        = opcode;
        dec_o.dst         = ic_i.word[23:16];
        dec_o.operands[0] = ic_i.word[15:8];
        dec_o.operands[1] = ic_i.word[7:0];

        // Unknown units read no registers
        dec_o.operands_required = 2'b00;
        case (opcode.eu)
            EU_IU: begin
                if (opcode.subtype inside {IU_ADD, IU_SUB, IU_AND, IU_OR, IU_XOR, IU_SLL}) begin
                    dec_o.operands_required = 2'b11;
                end else if (opcode.subtype inside {IU_ADDI, IU_SUBI, IU_SLLI}) begin
                    // Operand 0 field carries the immediate
                    dec_o.operands_required = 2'b10;
                end
            end
            EU_LSU: begin
                // Address and store data
                dec_o.operands_required = 2'b11;
            end
            default: begin
                dec_o.operands_required = 2'b00;
            end
        endcase
    end

endmodule : decoder

/* src/fetcher.sv */
// Warp fetcher
// Holds PC, mask and state per warp, launches warps and issues fetch requests
// One instruction per warp in flight, next PC comes back from the decoder
`include "bgpu_defs.svh"

module fetcher (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Warp launch
    input  logic                  launch_i,
    input  bgpu_pkg::wid_t        launch_wid_i,
    input  bgpu_pkg::pc_t         launch_pc_i,
    input  bgpu_pkg::act_mask_t   launch_mask_i,

    // To the instruction memory
    input  logic                  mem_ready_i,
    output logic                  fetch_valid_o,
    output bgpu_pkg::fetch_req_t  fetch_o,

    // From the decoder
    input  logic                  decoded_i,
    input  bgpu_pkg::wid_t        decoded_wid_i,
    input  bgpu_pkg::pc_t         decoded_next_pc_i,
    input  logic                  stop_i,
    output logic                  warp_done_o,
    output bgpu_pkg::wid_t        done_wid_o
);
    import bgpu_pkg::*;

    localparam int unsigned NumWarps = `BGPU_NUM_WARPS;

    warp_state_e state_q [NumWarps];
    pc_t         pc_q    [NumWarps];
    act_mask_t   mask_q  [NumWarps];

    logic [NumWarps-1:0] req;
    logic [NumWarps-1:0] gnt;
    logic [NumWarps-1:0] launch_hit;
    logic [NumWarps-1:0] decoded_hit;
    wid_t                gnt_wid;

    always_comb begin : warp_flags
        for (int unsigned w = 0; w < NumWarps; w++) begin
            req[w]         = state_q[w] == WS_READY;
            // Launches to a busy warp fall through here
            launch_hit[w]  = launch_i && launch_wid_i == wid_t'(w) && state_q[w] == WS_IDLE;
            decoded_hit[w] = decoded_i && decoded_wid_i == wid_t'(w);
        end
    end

    warp_arbiter i_warp_arbiter (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (req),
        .take_i    (fetch_valid_o),
        .gnt_o     (gnt),
        .gnt_wid_o (gnt_wid)
    );

    assign fetch_valid_o    = (|req) && mem_ready_i;
    assign fetch_o.wid      = gnt_wid;
    assign fetch_o.pc       = pc_q[gnt_wid];
    assign fetch_o.act_mask = mask_q[gnt_wid];

    assign warp_done_o = decoded_i && stop_i;
    assign done_wid_o  = decoded_wid_i;

    always_ff @(posedge clk_i) begin : state_table
        if (!rst_n_i) begin
            for (int unsigned w = 0; w < NumWarps; w++) begin
                state_q[w] <= WS_IDLE;
            end
        end else begin
            for (int unsigned w = 0; w < NumWarps; w++) begin
                if (launch_hit[w]) begin
                    state_q[w] <= WS_READY;
                end else if (fetch_valid_o && gnt[w]) begin
                    state_q[w] <= WS_WAITING;
                end else if (decoded_hit[w]) begin
                    state_q[w] <= stop_i ? WS_IDLE : WS_READY;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin : pc_table
        for (int unsigned w = 0; w < NumWarps; w++) begin
            if (launch_hit[w]) begin
                pc_q[w]   <= launch_pc_i;
                mask_q[w] <= launch_mask_i;
            end else if (decoded_hit[w] && !stop_i) begin
                pc_q[w] <= decoded_next_pc_i;
            end
        end
    end

endmodule : fetcher

/* src/front_end.sv */
// SIMT core front end
// Fetcher with warp arbitration, shared instruction memory and decoder
module front_end (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // Program load
    input  logic                 imem_we_i,
    input  bgpu_pkg::pc_t        imem_addr_i,
    input  bgpu_pkg::enc_inst_t  imem_wdata_i,

    // Warp launch
    input  logic                 launch_i,
    input  bgpu_pkg::wid_t       launch_wid_i,
    input  bgpu_pkg::pc_t        launch_pc_i,
    input  bgpu_pkg::act_mask_t  launch_mask_i,

    // To the dispatcher
    input  logic                 disp_ready_i,
    output logic                 dec_valid_o,
    output bgpu_pkg::dec_out_t   dec_o,
    output logic                 warp_done_o,
    output bgpu_pkg::wid_t       done_wid_o
);
    import bgpu_pkg::*;

    logic       fetch_valid;
    fetch_req_t fetch_req;
    logic       mem_ready;
    logic       ic_valid;
    ic_out_t    ic_out;
    logic       dec_ready;
    logic       decoded;
    logic       stop_warp;
    wid_t       decoded_wid;
    pc_t        decoded_next_pc;

    fetcher i_fetcher (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .launch_i          (launch_i),
        .launch_wid_i      (launch_wid_i),
        .launch_pc_i       (launch_pc_i),
        .launch_mask_i     (launch_mask_i),
        .mem_ready_i       (mem_ready),
        .fetch_valid_o     (fetch_valid),
        .fetch_o           (fetch_req),
        .decoded_i         (decoded),
        .decoded_wid_i     (decoded_wid),
        .decoded_next_pc_i (decoded_next_pc),
        .stop_i            (stop_warp),
        .warp_done_o       (warp_done_o),
        .done_wid_o        (done_wid_o)
    );

    inst_mem i_inst_mem (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .we_i        (imem_we_i),
        .waddr_i     (imem_addr_i),
        .wdata_i     (imem_wdata_i),
        .req_valid_i (fetch_valid),
        .req_i       (fetch_req),
        .ready_o     (mem_ready),
        .out_valid_o (ic_valid),
        .out_o       (ic_out),
        .out_ready_i (dec_ready)
    );

    decoder i_decoder (
        .ic_valid_i            (ic_valid),
        .ic_i                  (ic_out),
        .dec_ready_o           (dec_ready),
        .disp_ready_i          (disp_ready_i),
        .dec_valid_o           (dec_valid_o),
        .dec_o                 (dec_o),
        .dec_decoded_o         (decoded),
        .dec_stop_warp_o       (stop_warp),
        .dec_decoded_warp_id_o (decoded_wid),
        .dec_decoded_next_pc_o (decoded_next_pc)
    );

endmodule : front_end

/* src/inst_mem.sv */
// Instruction memory
// Word array with a write port and one registered read stage under back-pressure
`include "bgpu_defs.svh"

module inst_mem (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Program load
    input  logic                  we_i,
    input  bgpu_pkg::pc_t         waddr_i,
    input  bgpu_pkg::enc_inst_t   wdata_i,

    // Fetch requests
    input  logic                  req_valid_i,
    input  bgpu_pkg::fetch_req_t  req_i,
    output logic                  ready_o,

    // To the decoder
    output logic                  out_valid_o,
    output bgpu_pkg::ic_out_t     out_o,
    input  logic                  out_ready_i
);
    import bgpu_pkg::*;

    enc_inst_t mem_q [`BGPU_IMEM_DEPTH];
    logic      out_valid_q;
    ic_out_t   out_q;
    logic      accept;

    // Stage frees up in the same cycle its word is taken
    assign ready_o = !out_valid_q || out_ready_i;
    assign accept  = req_valid_i && ready_o;

    always_ff @(posedge clk_i) begin : write_port
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin : stage_valid
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
        end else if (accept) begin
            out_valid_q <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    // Held unchanged until the next accepted request
    always_ff @(posedge clk_i) begin : stage_data
        if (accept) begin
            out_q.req  <= req_i;
            out_q.word <= mem_q[req_i.pc];
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_o       = out_q;

endmodule : inst_mem

/* src/warp_arbiter.sv */
// Round-robin warp arbiter
// Grants the first requesting warp at or after a rotating priority pointer
`include "bgpu_defs.svh"

module warp_arbiter (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic [`BGPU_NUM_WARPS-1:0]  req_i,
    input  logic                        take_i,
    output logic [`BGPU_NUM_WARPS-1:0]  gnt_o,
    output bgpu_pkg::wid_t              gnt_wid_o
);
    import bgpu_pkg::*;

    localparam int unsigned NumWarps = `BGPU_NUM_WARPS;

    wid_t ptr_q;
    logic found;

    // Scan from the pointer and wrap around
    always_comb begin : pick
        int unsigned idx;
        found     = 1'b0;
        gnt_wid_o = '0;
        gnt_o     = '0;
        for (int unsigned i = 0; i < NumWarps; i++) begin
            idx = (int'(ptr_q) + i) % NumWarps;
            if (!found && req_i[idx]) begin
                found     = 1'b1;
                gnt_wid_o = wid_t'(idx);
            end
        end
        if (found) begin
            gnt_o[gnt_wid_o] = 1'b1;
        end
    end

    // Winner drops to lowest priority once its grant is used
    always_ff @(posedge clk_i) begin : pointer
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else if (take_i && found) begin
            ptr_q <= wid_t'((int'(gnt_wid_o) + 1) % NumWarps);
        end
    end

endmodule : warp_arbiter
